/* logic/rv_core_pkg.sv */
// Widths, enums and the control bundle shared by the RV32I pipeline
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_OP2
    } alu_fun_e;

    typedef enum logic [3:0] {
        NONE,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_e;

    typedef enum logic [2:0] {
        NO_JUMP,
        JUMP,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } jmp_e;

    typedef enum logic {
        RS1,
        PC
    } op1_sel_e;

    typedef enum logic [2:0] {
        RS2,
        I_IMM,
        S_IMM,
        B_IMM,
        U_IMM,
        J_IMM
    } op2_sel_e;

    // Operand source for decode forwarding
    typedef enum logic [1:0] {
        REG,
        EX,
        WB
    } fwd_sel_e;

    // wb is the register write enable
    typedef struct packed {
        alu_fun_e fun;
        mem_op_e  mem;
        jmp_e     jmp;
        logic     wb;
    } ctrl_t;

endpackage

/* logic/reg_file.sv */
// 32 x 32-bit register file, two asynchronous read ports and one write port
`timescale 1ns/1ns

module reg_file
    import rv_core_pkg::*;
(
    input  logic      down,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wd
);

    word_t regs [2**REG_ADDR_W];

    // x0 is hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

endmodule

/* logic/forward_unit.sv */
// Forwarding select logic for the two decode source operands
`timescale 1ns/1ns

module forward_unit
    import rv_core_pkg::*;
(
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      ex_valid,
    input  logic      ex_wb,
    input  reg_addr_t ex_rd,
    input  logic      res_valid,
    input  logic      res_we,
    input  reg_addr_t res_rd,
    output fwd_sel_e  rs1_sel,
    output fwd_sel_e  rs2_sel
);

    // Execute holds the youngest value, so it is checked first
    function automatic fwd_sel_e pick(input reg_addr_t addr, input logic ex_hit_ok,
                                      input reg_addr_t ex_dst, input logic wb_hit_ok,
                                      input reg_addr_t wb_dst);
        if (addr != '0 && ex_hit_ok && addr == ex_dst) begin
            return EX;
        end else if (addr != '0 && wb_hit_ok && addr == wb_dst) begin
            return WB;
        end
        return REG;
    endfunction

    always_comb begin
        rs1_sel = pick(rs1_addr, ex_valid & ex_wb, ex_rd, res_valid & res_we, res_rd);
        rs2_sel = pick(rs2_addr, ex_valid & ex_wb, ex_rd, res_valid & res_we, res_rd);
    end

endmodule

/* logic/decode.sv */
// RV32I decoder, immediate generation, operand forwarding and the decode-to-execute register
`timescale 1ns/1ns

module decode
    import rv_core_pkg::*;
(
    input  logic      down,
    input  logic      arst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_pc,
    input  word_t     in_inst,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     alu_data,
    input  word_t     wb_data,
    input  fwd_sel_e  rs1_sel,
    input  fwd_sel_e  rs2_sel,
    output logic      invalid,
    output logic      ex_valid,
    input  logic      ex_ready,
    output ctrl_t     ex_ctrl,
    output word_t     ex_pc,
    output word_t     ex_op1,
    output word_t     ex_op2,
    output word_t     ex_rs1,
    output word_t     ex_rs2,
    output reg_addr_t ex_rd
);

    // Base table entries; fun, mem and jmp are refined per funct3
    localparam ctrl_t C_KILL   = '{fun: ADD, mem: NONE, jmp: NO_JUMP, wb: 1'b0};
    localparam ctrl_t C_ALU    = '{fun: ADD, mem: NONE, jmp: NO_JUMP, wb: 1'b1};
    localparam ctrl_t C_JUMP   = '{fun: ADD, mem: NONE, jmp: JUMP,    wb: 1'b1};
    localparam ctrl_t C_BRANCH = '{fun: ADD, mem: NONE, jmp: BEQ,     wb: 1'b0};
    localparam ctrl_t C_MEM    = '{fun: ADD, mem: LW,   jmp: NO_JUMP, wb: 1'b0};

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ctrl_t      ctrl;
    op1_sel_e   op1_sel;
    op2_sel_e   op2_sel;
    logic       inval;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;
    word_t      rs1;
    word_t      rs2;
    word_t      op1;
    word_t      op2;
    logic       accept;

    assign opcode   = opcode_e'(in_inst[6:0]);
    assign funct3   = in_inst[14:12];
    assign funct7   = in_inst[31:25];
    assign rs1_addr = in_inst[19:15];
    assign rs2_addr = in_inst[24:20];

    function automatic alu_fun_e alu_fun(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    always_comb begin
        ctrl    = C_KILL;
        op1_sel = RS1;
        op2_sel = RS2;
        inval   = 1'b0;
        case (opcode)
            OP_IMM: begin
                ctrl     = C_ALU;
                op2_sel  = I_IMM;
                ctrl.fun = alu_fun(funct3, funct7[5] & (funct3 == 3'b101));
                // Shift immediates only allow the SRAI funct7 variant
                if (funct3 == 3'b001 && funct7 != 7'h00) begin
                    inval = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
                    inval = 1'b1;
                end
            end
            OP: begin
                ctrl     = C_ALU;
                ctrl.fun = alu_fun(funct3, funct7[5]);
                if (funct7 != 7'h00 &&
                    !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    inval = 1'b1;
                end
            end
            LUI: begin
                ctrl     = C_ALU;
                ctrl.fun = PASS_OP2;
                op2_sel  = U_IMM;
            end
            AUIPC: begin
                ctrl    = C_ALU;
                op1_sel = PC;
                op2_sel = U_IMM;
            end
            JAL: begin
                ctrl    = C_JUMP;
                op1_sel = PC;
                op2_sel = J_IMM;
            end
            JALR: begin
                ctrl    = C_JUMP;
                op2_sel = I_IMM;
                inval   = (funct3 != 3'b000);
            end
            BRANCH: begin
                ctrl    = C_BRANCH;
                op1_sel = PC;
                op2_sel = B_IMM;
                case (funct3)
                    3'b000:  ctrl.jmp = BEQ;
                    3'b001:  ctrl.jmp = BNE;
                    3'b100:  ctrl.jmp = BLT;
                    3'b101:  ctrl.jmp = BGE;
                    3'b110:  ctrl.jmp = BLTU;
                    3'b111:  ctrl.jmp = BGEU;
                    default: inval = 1'b1;
                endcase
            end
            LOAD: begin
                ctrl    = C_MEM;
                op2_sel = I_IMM;
                case (funct3)
                    3'b000:  ctrl.mem = LB;
                    3'b001:  ctrl.mem = LH;
                    3'b010:  ctrl.mem = LW;
                    3'b100:  ctrl.mem = LBU;
                    3'b101:  ctrl.mem = LHU;
                    default: inval = 1'b1;
                endcase
            end
            STORE: begin
                ctrl    = C_MEM;
                op2_sel = S_IMM;
                case (funct3)
                    3'b000:  ctrl.mem = SB;
                    3'b001:  ctrl.mem = SH;
                    3'b010:  ctrl.mem = SW;
                    default: inval = 1'b1;
                endcase
            end
            default: inval = 1'b1;
        endcase
        // Unknown encodings travel on as bubbles
        if (inval) begin
            ctrl = C_KILL;
        end
    end

    assign i_imm = {{20{in_inst[31]}}, in_inst[31:20]};
    assign s_imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    assign b_imm = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                    in_inst[11:8], 1'b0};
    assign u_imm = {in_inst[31:12], 12'b0};
    assign j_imm = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                    in_inst[30:21], 1'b0};

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t ex_val, input word_t wb_val);
        case (sel)
            EX:      return ex_val;
            WB:      return wb_val;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        rs1 = fwd_mux(rs1_sel, rs1_data, alu_data, wb_data);
        rs2 = fwd_mux(rs2_sel, rs2_data, alu_data, wb_data);
        op1 = (op1_sel == PC) ? in_pc : rs1;
        case (op2_sel)
            I_IMM:   op2 = i_imm;
            S_IMM:   op2 = s_imm;
            B_IMM:   op2 = b_imm;
            U_IMM:   op2 = u_imm;
            J_IMM:   op2 = j_imm;
            default: op2 = rs2;
        endcase
    end

    assign in_ready = !ex_valid || ex_ready;
    assign accept   = in_valid && in_ready;
    assign invalid  = accept && inval;

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= C_KILL;
        end else if (accept) begin
            ex_valid <= 1'b1;
            ex_ctrl  <= ctrl;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge down) begin
        if (accept) begin
            ex_pc  <= in_pc;
            ex_op1 <= op1;
            ex_op2 <= op2;
            ex_rs1 <= rs1;
            ex_rs2 <= rs2;
            ex_rd  <= in_inst[11:7];
        end
    end

endmodule

/* logic/execute.sv */
// ALU, branch compare, jump target and link logic with the result register
`timescale 1ns/1ns

module execute
    import rv_core_pkg::*;
(
    input  logic      down,
    input  logic      arst_n,
    input  logic      ex_valid,
    output logic      ex_ready,
    input  ctrl_t     ex_ctrl,
    input  word_t     ex_pc,
    input  word_t     ex_op1,
    input  word_t     ex_op2,
    input  word_t     ex_rs1,
    input  word_t     ex_rs2,
    input  reg_addr_t ex_rd,
    output word_t     alu_data,
    output logic      res_valid,
    input  logic      res_ready,
    output word_t     res_pc,
    output word_t     res_value,
    output reg_addr_t res_rd,
    output logic      res_we,
    output mem_op_e   res_mem,
    output word_t     res_addr,
    output word_t     res_store_data,
    output word_t     res_target,
    output logic      res_taken
);

    word_t      result;
    word_t      link;
    word_t      target;
    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       taken;
    logic       is_store;
    logic       advance;

    assign shamt = ex_op2[4:0];

    always_comb begin
        case (ex_ctrl.fun)
            SUB:      result = ex_op1 - ex_op2;
            SLL:      result = ex_op1 << shamt;
            SLT:      result = {31'b0, $signed(ex_op1) < $signed(ex_op2)};
            SLTU:     result = {31'b0, ex_op1 < ex_op2};
            XOR:      result = ex_op1 ^ ex_op2;
            SRL:      result = ex_op1 >> shamt;
            SRA:      result = word_t'($signed(ex_op1) >>> shamt);
            OR:       result = ex_op1 | ex_op2;
            AND:      result = ex_op1 & ex_op2;
            PASS_OP2: result = ex_op2;
            default:  result = ex_op1 + ex_op2;
        endcase
    end

    // Branches compare the register values, not the operands
    assign eq  = (ex_rs1 == ex_rs2);
    assign lt  = ($signed(ex_rs1) < $signed(ex_rs2));
    assign ltu = (ex_rs1 < ex_rs2);

    always_comb begin
        case (ex_ctrl.jmp)
            JUMP:    taken = 1'b1;
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt;
            BGE:     taken = !lt;
            BLTU:    taken = ltu;
            BGEU:    taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    assign link = ex_pc + 32'd4;

    // JALR needs bit 0 cleared; JAL targets are already even
    always_comb begin
        case (ex_ctrl.jmp)
            NO_JUMP: target = '0;
            JUMP:    target = {result[31:1], 1'b0};
            default: target = result;
        endcase
    end

    // Value the held instruction will write, also used for forwarding
    assign alu_data = (ex_ctrl.jmp == JUMP) ? link : result;

    assign is_store = (ex_ctrl.mem == SB) || (ex_ctrl.mem == SH) || (ex_ctrl.mem == SW);
    assign ex_ready = !res_valid || res_ready;
    assign advance  = ex_valid && ex_ready;

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            res_we    <= 1'b0;
            res_mem   <= NONE;
            res_taken <= 1'b0;
        end else if (advance) begin
            res_valid <= 1'b1;
            res_we    <= ex_ctrl.wb;
            res_mem   <= ex_ctrl.mem;
            res_taken <= taken;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge down) begin
        if (advance) begin
            res_pc         <= ex_pc;
            res_rd         <= ex_rd;
            res_value      <= ex_ctrl.wb ? alu_data : '0;
            res_addr       <= (ex_ctrl.mem != NONE) ? result : '0;
            res_store_data <= is_store ? ex_rs2 : '0;
            res_target     <= target;
        end
    end

endmodule

/* logic/core_top.sv */
// Pipeline top connecting decode, forwarding, execute and the register file
`timescale 1ns/1ns

module core_top
    import rv_core_pkg::*;
(
    input  logic      down,
    input  logic      arst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_pc,
    input  word_t     in_inst,
    output logic      res_valid,
    input  logic      res_ready,
    output word_t     res_pc,
    output reg_addr_t res_rd,
    output logic      res_we,
    output word_t     res_value,
    output mem_op_e   res_mem,
    output word_t     res_addr,
    output word_t     res_store_data,
    output logic      res_taken,
    output word_t     res_target,
    output logic      invalid
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    fwd_sel_e  rs1_sel;
    fwd_sel_e  rs2_sel;
    word_t     alu_data;
    logic      ex_valid;
    logic      ex_ready;
    ctrl_t     ex_ctrl;
    word_t     ex_pc;
    word_t     ex_op1;
    word_t     ex_op2;
    word_t     ex_rs1;
    word_t     ex_rs2;
    reg_addr_t ex_rd;
    logic      wb_we;

    // Results retire into the register file on the output transfer
    assign wb_we = res_valid && res_ready && res_we;

    decode u_decode (
        .down     (down),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_data (alu_data),
        .wb_data  (res_value),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .invalid  (invalid),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_ctrl  (ex_ctrl),
        .ex_pc    (ex_pc),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2),
        .ex_rs1   (ex_rs1),
        .ex_rs2   (ex_rs2),
        .ex_rd    (ex_rd)
    );

    forward_unit u_forward_unit (
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .ex_valid  (ex_valid),
        .ex_wb     (ex_ctrl.wb),
        .ex_rd     (ex_rd),
        .res_valid (res_valid),
        .res_we    (res_we),
        .res_rd    (res_rd),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel)
    );

    execute u_execute (
        .down           (down),
        .arst_n         (arst_n),
        .ex_valid       (ex_valid),
        .ex_ready       (ex_ready),
        .ex_ctrl        (ex_ctrl),
        .ex_pc          (ex_pc),
        .ex_op1         (ex_op1),
        .ex_op2         (ex_op2),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_rd          (ex_rd),
        .alu_data       (alu_data),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_pc         (res_pc),
        .res_value      (res_value),
        .res_rd         (res_rd),
        .res_we         (res_we),
        .res_mem        (res_mem),
        .res_addr       (res_addr),
        .res_store_data (res_store_data),
        .res_target     (res_target),
        .res_taken      (res_taken)
    );

    reg_file u_reg_file (
        .down     (down),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_we),
        .rd       (res_rd),
        .wd       (res_value)
    );

endmodule

/* verif/core_top_tb.sv */
// Trace-driven testbench for core_top with clock, reset, driver, checker and watchdog
`timescale 1ns/1ns

module core_top_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_CYCLES = 16;
    localparam int TRACE_WORDS = 1024;
    // Columns of one trace record
    localparam int REC_WORDS   = 11;
    localparam logic [31:0] SEED = 32'h2eed_f3dc;

    logic        down;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    logic [31:0] in_inst;
    logic        res_valid;
    logic        res_ready;
    logic [31:0] res_pc;
    logic [4:0]  res_rd;
    logic        res_we;
    logic [31:0] res_value;
    logic [3:0]  res_mem;
    logic [31:0] res_addr;
    logic [31:0] res_store_data;
    logic        res_taken;
    logic [31:0] res_target;
    logic        invalid;

    logic [31:0] trace_mem [0:TRACE_WORDS-1];
    logic [31:0] lfsr;
    int          n_rec = 0;
    int          issued = 0;
    int          checked = 0;
    int          errors = 0;
    int          cycle = 0;
    logic        in_fire = 1'b0;
    int          accept_q [$];

    core_top dut (
        .down           (down),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_pc          (in_pc),
        .in_inst        (in_inst),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_pc         (res_pc),
        .res_rd         (res_rd),
        .res_we         (res_we),
        .res_value      (res_value),
        .res_mem        (res_mem),
        .res_addr       (res_addr),
        .res_store_data (res_store_data),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .invalid        (invalid)
    );

    initial begin
        down = 1'b0;
        forever #(CLK_PERIOD / 2) down = ~down;
    end

    function automatic logic [31:0] field(input int rec, input int col);
        return trace_mem[1 + rec * REC_WORDS + col];
    endfunction

    // Right-shifting Galois form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_result(input int rec);
        check_value("res_pc", field(rec, 0), res_pc);
        // rd only matters for writing instructions
        if (field(rec, 3) == 32'd1) begin
            check_value("res_rd", field(rec, 2), res_rd);
        end
        check_value("res_we", field(rec, 3), res_we);
        check_value("res_value", field(rec, 4), res_value);
        check_value("res_mem", field(rec, 5), res_mem);
        check_value("res_addr", field(rec, 6), res_addr);
        check_value("res_store_data", field(rec, 7), res_store_data);
        check_value("res_taken", field(rec, 8), res_taken);
        check_value("res_target", field(rec, 9), res_target);
    endtask

    task automatic present_record(input int idx);
        in_valid = 1'b1;
        in_pc    = field(idx % n_rec, 0);
        in_inst  = field(idx % n_rec, 1);
    endtask

    // First pass streams without gaps or back-pressure and the second pass is randomized
    task automatic run_stream();
        logic [31:0] bits;
        int          total;
        total = 2 * n_rec;
        while (checked < total) begin
            @(posedge down);
            #1;
            if (in_fire) begin
                issued++;
                in_valid = 1'b0;
            end
            if (checked < n_rec) begin
                res_ready = 1'b1;
            end else begin
                draw_bits(1, bits);
                res_ready = bits[0];
            end
            if (!in_valid && issued < total) begin
                if (issued < n_rec) begin
                    present_record(issued);
                end else begin
                    draw_bits(2, bits);
                    if (bits[1:0] != 2'b00) begin
                        present_record(issued);
                    end
                end
            end
        end
        in_valid  = 1'b0;
        res_ready = 1'b1;
        repeat (10) @(posedge down);
    endtask

    // Handshakes are sampled mid-cycle and transfer on the next rising edge
    always @(negedge down) begin : result_monitor
        int rec;
        int latency;
        if (arst_n) begin
            cycle++;
            in_fire = in_valid && in_ready;
            if (in_fire) begin
                rec = issued % n_rec;
                check_value("invalid", field(rec, 10), invalid);
                accept_q.push_back(cycle);
            end
            if (res_valid && res_ready) begin
                if (checked >= 2 * n_rec || accept_q.size() == 0) begin
                    errors++;
                    $display("Unexpected result for pc %h with no instruction left to match",
                             res_pc);
                end else begin
                    rec     = checked % n_rec;
                    latency = cycle - accept_q.pop_front();
                    if (checked < n_rec) begin
                        check_value("latency", 32'd2, latency);
                    end
                    compare_result(rec);
                    checked++;
                end
            end
        end
    end

    initial begin : main_flow
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        res_ready = 1'b0;
        lfsr      = SEED;
        $readmemh("verif/core_trace.txt", trace_mem);
        if (trace_mem[0] === 'x || trace_mem[0] == 0) begin
            errors++;
            $display("Trace file verif/core_trace.txt is missing or holds no records");
        end else begin
            n_rec = trace_mem[0];
            repeat (RESET_CYCLES) @(posedge down);
            #1;
            arst_n = 1'b1;
            run_stream();
        end
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (n_rec > 0);
        #((RESET_CYCLES + 40 * 2 * n_rec + 10) * CLK_PERIOD);
        $display("Watchdog expired after %0d of %0d results, the pipeline stopped responding",
                 checked, 2 * n_rec);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* files.f */
logic/rv_core_pkg.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/decode.sv
logic/execute.sv
logic/core_top.sv
verif/core_top_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/reg_file.sv
  - logic/forward_unit.sv
  - logic/decode.sv
  - logic/execute.sv
  - logic/core_top.sv
  - target: test
    files:
      - verif/core_top_tb.sv

/* verif/core_trace.txt */
// First word: record count. Each record: pc inst rd we value mem addr store_data taken target invalid
// rd is only compared when we is 1; mem codes NONE 0 LB 1 LH 2 LW 3 LBU 4 LHU 5 SB 6 SH 7 SW 8
0000001C
00000000 00500093 01 1 00000005 0 00000000 00000000 0 00000000 0
00000004 FFD00113 02 1 FFFFFFFD 0 00000000 00000000 0 00000000 0
00000008 002081B3 03 1 00000002 0 00000000 00000000 0 00000000 0
0000000C 40208233 04 1 00000008 0 00000000 00000000 0 00000000 0
00000010 401152B3 05 1 FFFFFFFF 0 00000000 00000000 0 00000000 0
00000014 00112333 06 1 00000001 0 00000000 00000000 0 00000000 0
00000018 001133B3 07 1 00000000 0 00000000 00000000 0 00000000 0
0000001C 12345437 08 1 12345000 0 00000000 00000000 0 00000000 0
00000020 00001497 09 1 00001020 0 00000000 00000000 0 00000000 0
00000024 0080056F 0A 1 00000028 0 00000000 00000000 1 0000002C 0
00000028 004085E7 0B 1 0000002C 0 00000000 00000000 1 00000008 0
0000002C 00108863 00 0 00000000 0 00000000 00000000 1 0000003C 0
00000030 00109463 00 0 00000000 0 00000000 00000000 0 00000038 0
00000034 FE114EE3 00 0 00000000 0 00000000 00000000 1 00000030 0
00000038 00115663 00 0 00000000 0 00000000 00000000 0 00000044 0
0000003C 00116463 00 0 00000000 0 00000000 00000000 0 00000044 0
00000040 FE1178E3 00 0 00000000 0 00000000 00000000 1 00000030 0
00000044 0080A603 00 0 00000000 3 0000000D 00000000 0 00000000 0
00000048 FE41AE23 00 0 00000000 8 FFFFFFFE 00000008 0 00000000 0
0000004C FFFFFFFF 00 0 00000000 0 00000000 00000000 0 00000000 1
00000050 FFF44693 0D 1 EDCBAFFF 0 00000000 00000000 0 00000000 0
00000054 40115713 0E 1 FFFFFFFE 0 00000000 00000000 0 00000000 0
00000058 00409793 0F 1 00000050 0 00000000 00000000 0 00000000 0
0000005C 00E7E833 10 1 FFFFFFFE 0 00000000 00000000 0 00000000 0
00000060 0036F8B3 11 1 00000002 0 00000000 00000000 0 00000000 0
00000064 02108933 00 0 00000000 0 00000000 00000000 0 00000000 1
00000068 001609B3 13 1 00000005 0 00000000 00000000 0 00000000 0
0000006C 01098A33 14 1 00000003 0 00000000 00000000 0 00000000 0
